//--- Bender.yml
package:
  name: conv_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/conv_pkg.sv
      - hdl/mem_bus_if.sv
      - hdl/frame_ram.sv
      - hdl/mem_arbiter.sv
      - hdl/window_fetch.sv
      - hdl/conv3x3_core.sv
      - hdl/result_store.sv
      - hdl/conv_engine.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/conv_engine_tb.sv

//--- hdl/conv3x3_core.sv
`timescale 1ns/100ps
`default_nettype none

module conv3x3_core (
  input  logic              clk,
  input  logic              reset,
  input  logic              kernel_we,
  input  logic [3:0]        kernel_idx,
  input  logic [7:0]        kernel_data,
  input  conv_pkg::window_t win,
  input  logic              win_valid,
  output logic [19:0]       result,
  output logic              res_valid
);
  import conv_pkg::*;

  kernel_t          kernel;
  logic [8:0][15:0] prod;        // Stage 1
  logic             prod_valid;
  logic [3:0][16:0] sum1;
  logic [1:0][17:0] sum2;
  logic [18:0]      sum3;
  logic [19:0]      total;       // Nine full products need 20 bits

  always_ff @(posedge clk) begin
    if (kernel_we) begin
      kernel[kernel_idx] <= kernel_data;
    end
  end

  // *************************************************************************
  // Stage 1, nine exact unsigned products
  // *************************************************************************

  always_ff @(posedge clk) begin
    for (int k = 0; k < 9; k++) begin
      prod[k] <= win[k] * kernel[k];
    end
  end

  // *************************************************************************
  // Stage 2, adder tree
  // *************************************************************************

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      sum1[i] = 17'(prod[2*i]) + 17'(prod[2*i+1]);
    end
    for (int j = 0; j < 2; j++) begin
      sum2[j] = 18'(sum1[2*j]) + 18'(sum1[2*j+1]);
    end
    sum3  = 19'(sum2[0]) + 19'(sum2[1]);
    total = 20'(sum3) + 20'(prod[8]);  // Odd product joins last
  end

  always_ff @(posedge clk) begin
    result <= total;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      res_valid  <= 1'b0;
    end else begin
      prod_valid <= win_valid;
      res_valid  <= prod_valid;
    end
  end

  a_kernel_idx : assert property (@(posedge clk) disable iff (reset)
    kernel_we |-> kernel_idx < 4'd9);

endmodule

`default_nettype wire

//--- hdl/conv_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_params.svh"

module conv_engine (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               kernel_we,
  input  logic [3:0]         kernel_idx,
  input  logic [7:0]         kernel_data,
  input  logic               host_req,
  input  logic               host_we,
  input  logic [`MEM_AW-1:0] host_addr,
  input  logic [19:0]        host_wdata,
  output logic               host_gnt,
  output logic [19:0]        host_rdata,
  output logic               host_rvalid,
  output logic               busy,
  output logic               done
);
  import conv_pkg::*;

  mem_bus_if host_bus ();
  mem_bus_if fetch_bus ();
  mem_bus_if store_bus ();

  window_t     win;
  logic        win_valid;
  logic        space_ok;
  logic [19:0] result;
  logic        res_valid;

  // Host side of the shared memory port
  assign host_bus.req       = host_req;
  assign host_bus.we        = host_we;
  assign host_bus.addr      = host_addr;
  assign host_bus.wdata.res = host_wdata;
  assign host_gnt           = host_bus.gnt;
  assign host_rdata         = host_bus.rdata.res;  // Result view
  assign host_rvalid        = host_bus.rvalid;

  mem_arbiter u_arbiter (
    .clk   (clk),
    .reset (reset),
    .host  (host_bus.arbiter),
    .fetch (fetch_bus.arbiter),
    .store (store_bus.arbiter)
  );

  window_fetch u_fetch (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .space_ok  (space_ok),
    .done      (done),
    .mem       (fetch_bus.requester),
    .win       (win),
    .win_valid (win_valid),
    .busy      (busy)
  );

  conv3x3_core u_core (
    .clk         (clk),
    .reset       (reset),
    .kernel_we   (kernel_we),
    .kernel_idx  (kernel_idx),
    .kernel_data (kernel_data),
    .win         (win),
    .win_valid   (win_valid),
    .result      (result),
    .res_valid   (res_valid)
  );

  result_store u_store (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .win_valid (win_valid),
    .result    (result),
    .res_valid (res_valid),
    .mem       (store_bus.requester),
    .space_ok  (space_ok),
    .done      (done)
  );

endmodule

`default_nettype wire

//--- hdl/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// *************************************************************************
// Image and frame memory geometry
// *************************************************************************

`define IMG_W 8
`define IMG_H 8

// Valid 3x3 outputs, no padding
`define OUT_W (`IMG_W - 2)
`define OUT_H (`IMG_H - 2)

`define MEM_AW   7   // 128 words
`define WORD_W   20
`define RES_BASE 64  // Results follow the image

`define STORE_DEPTH 4

`endif

//--- hdl/conv_pkg.sv
`default_nettype none
`include "conv_params.svh"

package conv_pkg;

  // Pixel view of a memory word
  typedef struct packed {
    logic [`WORD_W-9:0] pad;
    logic [7:0]         value;
  } pix_word_t;

  // One frame memory word, read as a pixel or as a result
  typedef union packed {
    pix_word_t          pix;
    logic [`WORD_W-1:0] res;
  } mem_word_t;

  // Index k is window row k/3, column k%3
  typedef logic [8:0][7:0] kernel_t;
  typedef logic [8:0][7:0] window_t;

endpackage

`default_nettype wire

//--- hdl/frame_ram.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_params.svh"

module frame_ram (
  input  logic                clk,
  input  logic                we,
  input  logic [`MEM_AW-1:0]  addr,
  input  conv_pkg::mem_word_t wdata,
  output conv_pkg::mem_word_t rdata
);
  import conv_pkg::*;

  localparam int DEPTH = 1 << `MEM_AW;

  // Image at the bottom, results from RES_BASE up
  mem_word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];  // Registered read, old data on a write
  end

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_params.svh"

module mem_arbiter (
  input logic        clk,
  input logic        reset,
  mem_bus_if.arbiter host,
  mem_bus_if.arbiter fetch,
  mem_bus_if.arbiter store
);
  import conv_pkg::*;

  logic               gnt_h;
  logic               gnt_f;
  logic               gnt_s;
  logic               rr_store;  // Store wins the next fetch/store tie
  logic               rv_h;
  logic               rv_f;
  logic               rv_s;
  logic               ram_we;
  logic [`MEM_AW-1:0] ram_addr;
  mem_word_t          ram_wdata;
  mem_word_t          ram_rdata;

  // Host first, then fetcher and store take turns
  always_comb begin
    gnt_h = host.req;
    gnt_f = !host.req && fetch.req && (!store.req || !rr_store);
    gnt_s = !host.req && store.req && (!fetch.req || rr_store);
  end

  always_comb begin
    ram_we    = 1'b0;
    ram_addr  = store.addr;
    ram_wdata = store.wdata;
    if (gnt_h) begin
      ram_we    = host.we;
      ram_addr  = host.addr;
      ram_wdata = host.wdata;
    end else if (gnt_f) begin
      ram_we    = fetch.we;
      ram_addr  = fetch.addr;
      ram_wdata = fetch.wdata;
    end else if (gnt_s) begin
      ram_we    = store.we;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rr_store <= 1'b0;
      rv_h     <= 1'b0;
      rv_f     <= 1'b0;
      rv_s     <= 1'b0;
    end else begin
      if (gnt_f) begin
        rr_store <= 1'b1;
      end else if (gnt_s) begin
        rr_store <= 1'b0;
      end
      rv_h <= gnt_h && !host.we;   // Remember who owns the read
      rv_f <= gnt_f && !fetch.we;
      rv_s <= gnt_s && !store.we;
    end
  end

  frame_ram u_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  assign host.gnt     = gnt_h;
  assign fetch.gnt    = gnt_f;
  assign store.gnt    = gnt_s;
  assign host.rdata   = ram_rdata;
  assign fetch.rdata  = ram_rdata;
  assign store.rdata  = ram_rdata;
  assign host.rvalid  = rv_h;
  assign fetch.rvalid = rv_f;
  assign store.rvalid = rv_s;

  // A waiting requester keeps its request and fields until granted
  a_fetch_hold : assert property (@(posedge clk) disable iff (reset)
    fetch.req && !gnt_f |=> fetch.req && $stable(fetch.addr));

  a_store_hold : assert property (@(posedge clk) disable iff (reset)
    store.req && !gnt_s |=> store.req && $stable(store.addr) && $stable(store.wdata));

endmodule

`default_nettype wire

//--- hdl/mem_bus_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_params.svh"

interface mem_bus_if;
  import conv_pkg::*;

  logic               req;
  logic               we;
  logic [`MEM_AW-1:0] addr;
  mem_word_t          wdata;
  logic               gnt;    // Access reaches the RAM this cycle
  mem_word_t          rdata;
  logic               rvalid; // One cycle after a read grant

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

`default_nettype wire

//--- hdl/result_store.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_params.svh"

module result_store (
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  logic         win_valid,
  input  logic [19:0]  result,
  input  logic         res_valid,
  mem_bus_if.requester mem,
  output logic         space_ok,
  output logic         done
);

  localparam int PW    = $clog2(`STORE_DEPTH);
  localparam int N_RES = `OUT_W * `OUT_H;

  logic [19:0]        queue [`STORE_DEPTH];
  logic [PW-1:0]      rd_ptr;
  logic [PW-1:0]      wr_ptr;
  logic [PW:0]        count;
  logic [PW:0]        inflight;  // Windows still inside the core
  logic [PW+1:0]      pending;
  logic [5:0]         written;
  logic [`MEM_AW-1:0] waddr;
  logic               active;
  logic               pop;

  assign pop      = mem.gnt;
  assign pending  = count + inflight + win_valid;
  assign space_ok = (pending < `STORE_DEPTH);

  assign mem.req       = (count != '0);
  assign mem.we        = 1'b1;
  assign mem.addr      = waddr;
  assign mem.wdata.res = queue[rd_ptr];  // Head stays put until granted

  always_ff @(posedge clk) begin
    if (res_valid) begin
      queue[wr_ptr] <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
      inflight <= '0;
      written  <= '0;
      waddr    <= `MEM_AW'(`RES_BASE);
      active   <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !active) begin  // Start during a run is dropped
        active  <= 1'b1;
        written <= '0;
        waddr   <= `MEM_AW'(`RES_BASE);
      end
      if (res_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr  <= rd_ptr + 1'b1;
        waddr   <= waddr + 1'b1;
        written <= written + 6'd1;
        if (written == 6'(N_RES - 1)) begin
          done   <= 1'b1;
          active <= 1'b0;
        end
      end
      count    <= count + res_valid - pop;
      inflight <= inflight + win_valid - res_valid;
    end
  end

  a_no_overflow : assert property (@(posedge clk) disable iff (reset)
    res_valid |-> (count < `STORE_DEPTH) || pop);

endmodule

`default_nettype wire

//--- hdl/window_fetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_params.svh"

module window_fetch (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic              space_ok,
  input  logic              done,      // Run finished in result_store
  mem_bus_if.requester      mem,
  output conv_pkg::window_t win,
  output logic              win_valid,
  output logic              busy
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_NEXT,     // Wait for room downstream
    S_ISSUE,    // Nine reads, one per grant
    S_COLLECT,  // Last read data still due
    S_DRAIN     // All windows sent, wait for the final write
  } state_t;

  state_t     state;
  logic [2:0] orow;
  logic [2:0] ocol;
  logic [3:0] tap;    // Tap being requested
  logic [3:0] rtap;   // Tap being returned
  logic [3:0] tap_r;
  logic [3:0] tap_c;
  logic       last_col;
  logic       last_pos;

  assign tap_r    = tap / 4'd3;
  assign tap_c    = tap % 4'd3;
  assign last_col = (ocol == 3'(`OUT_W - 1));
  assign last_pos = last_col && (orow == 3'(`OUT_H - 1));

  assign mem.req   = (state == S_ISSUE);
  assign mem.we    = 1'b0;
  assign mem.addr  = `MEM_AW'((orow + tap_r) * `IMG_W + ocol + tap_c);
  assign mem.wdata = '0;

  // *************************************************************************
  // Position and tap sequencing
  // *************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_IDLE;
      busy      <= 1'b0;
      win_valid <= 1'b0;
      orow      <= '0;
      ocol      <= '0;
      tap       <= '0;
      rtap      <= '0;
    end else begin
      win_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            busy  <= 1'b1;
            orow  <= '0;
            ocol  <= '0;
            tap   <= '0;
            rtap  <= '0;
            state <= S_NEXT;
          end
        end
        S_NEXT: begin
          if (space_ok) begin
            state <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          if (mem.gnt) begin
            if (tap == 4'd8) begin
              tap   <= '0;
              state <= S_COLLECT;
            end else begin
              tap <= tap + 4'd1;
            end
          end
        end
        S_COLLECT: begin
          if (mem.rvalid && rtap == 4'd8) begin
            win_valid <= 1'b1;
            if (last_pos) begin
              state <= S_DRAIN;
            end else begin
              state <= S_NEXT;
              if (last_col) begin
                ocol <= '0;
                orow <= orow + 3'd1;
              end else begin
                ocol <= ocol + 3'd1;
              end
            end
          end
        end
        S_DRAIN: begin
          if (done) begin
            busy  <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
      if (mem.rvalid) begin
        rtap <= (rtap == 4'd8) ? 4'd0 : rtap + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem.rvalid) begin
      win[rtap] <= mem.rdata.pix.value;  // Pixel view of the word
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/mem_bus_if.sv
hdl/frame_ram.sv
hdl/mem_arbiter.sv
hdl/window_fetch.sv
hdl/conv3x3_core.sv
hdl/result_store.sv
hdl/conv_engine.sv
verif/conv_engine_tb.sv

//--- verif/conv_engine_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_params.svh"

module conv_engine_tb;

  localparam int N_PIX      = `IMG_W * `IMG_H;
  localparam int MAX_CYCLES = 6 * 1000;  // Six runs, loading and read-back included

  logic               clk;
  logic               reset;
  logic               start;
  logic               kernel_we;
  logic [3:0]         kernel_idx;
  logic [7:0]         kernel_data;
  logic               host_req;
  logic               host_we;
  logic [`MEM_AW-1:0] host_addr;
  logic [19:0]        host_wdata;
  logic               host_gnt;
  logic [19:0]        host_rdata;
  logic               host_rvalid;
  logic               busy;
  logic               done;

  logic [7:0]  img [N_PIX];  // Reference copy of the frame image
  logic [7:0]  kern [9];
  int          errors;
  int          cycles;
  int          done_count;
  bit          run_over;
  int unsigned seed;

  conv_engine DUT (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .kernel_we   (kernel_we),
    .kernel_idx  (kernel_idx),
    .kernel_data (kernel_data),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_gnt    (host_gnt),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .busy        (busy),
    .done        (done)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles (%0d errors so far)",
               MAX_CYCLES, errors);
      $display("*** FAILED ***");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (done) done_count++;
  end

  // *************************************************************************
  // Reference model and host port access
  // *************************************************************************

  // Sum over the 3x3 window of pixel times coefficient
  function automatic logic [19:0] conv_ref(input int r, input int c);
    logic [19:0] acc;
    acc = '0;
    for (int k = 0; k < 9; k++) begin
      acc += img[(r + k / 3) * `IMG_W + c + k % 3] * kern[k];
    end
    return acc;
  endfunction

  task automatic host_write(input logic [`MEM_AW-1:0] addr, input logic [19:0] data);
    @(posedge clk);
    #10;
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(negedge clk);
    while (!host_gnt) @(negedge clk);
    @(posedge clk);
    #10;
    host_req = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic host_read(input logic [`MEM_AW-1:0] addr, output logic [19:0] data);
    @(posedge clk);
    #10;
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    @(negedge clk);
    while (!host_gnt) @(negedge clk);
    @(posedge clk);
    #10;
    host_req = 1'b0;
    @(negedge clk);  // Read data is due one cycle after the grant
    assert (host_rvalid) else begin
      errors++;
      $display("host_rvalid missing one cycle after the read grant, address %0d", addr);
    end
    data = host_rdata;
  endtask

  task automatic load_image;
    for (int a = 0; a < N_PIX; a++) begin
      host_write(`MEM_AW'(a), {12'h000, img[a]});
    end
  endtask

  task automatic load_kernel;
    @(posedge clk);
    #10;
    for (int k = 0; k < 9; k++) begin
      kernel_we   = 1'b1;
      kernel_idx  = 4'(k);
      kernel_data = kern[k];
      @(posedge clk);
      #10;
    end
    kernel_we = 1'b0;
  endtask

  task automatic pulse_start;
    @(posedge clk);
    #10;
    start = 1'b1;
    @(posedge clk);
    #10;
    start = 1'b0;
  endtask

  task automatic run_conv(input string name);
    pulse_start;
    @(negedge clk);
    assert (busy) else begin
      errors++;
      $display("%s: busy did not rise after start", name);
    end
    while (!done) @(negedge clk);
  endtask

  task automatic check_results(input string name);
    logic [19:0] got;
    logic [19:0] expected;
    for (int r = 0; r < `OUT_H; r++) begin
      for (int c = 0; c < `OUT_W; c++) begin
        expected = conv_ref(r, c);
        host_read(`MEM_AW'(`RES_BASE + r * `OUT_W + c), got);
        assert (got === expected) else begin
          errors++;
          $display("Mismatch %s result (%0d,%0d): expected %0d actual %0d",
                   name, r, c, expected, got);
        end
      end
    end
  endtask

  // *************************************************************************
  // Directed tests
  // *************************************************************************

  task automatic reset_state;
    logic [19:0] got;
    @(negedge clk);
    assert (!busy && !done && !host_gnt && !host_rvalid) else begin
      errors++;
      $display("reset_state: outputs not idle after reset");
    end
    host_write(7'd127, 20'hA5C3E);
    host_read(7'd127, got);
    assert (got === 20'hA5C3E) else begin
      errors++;
      $display("Mismatch reset_state: expected %0d actual %0d", 20'hA5C3E, got);
    end
  endtask

  task automatic identity_kernel;
    for (int a = 0; a < N_PIX; a++) img[a] = 8'(a);  // Ramp image
    for (int k = 0; k < 9; k++) kern[k] = (k == 4) ? 8'd1 : 8'd0;
    load_image;
    load_kernel;
    run_conv("identity_kernel");
    check_results("identity_kernel");
  endtask

  task automatic ones_kernel_ramp;
    for (int k = 0; k < 9; k++) kern[k] = 8'd1;
    load_kernel;  // Ramp image is still in memory
    run_conv("ones_kernel_ramp");
    check_results("ones_kernel_ramp");
  endtask

  task automatic worst_case_magnitude;
    logic [19:0] got;
    for (int a = 0; a < N_PIX; a++) img[a] = 8'd255;
    for (int k = 0; k < 9; k++) kern[k] = 8'd255;
    load_image;
    load_kernel;
    run_conv("worst_case_magnitude");
    check_results("worst_case_magnitude");
    host_read(`MEM_AW'(`RES_BASE), got);
    assert (got === 20'd585225) else begin
      errors++;
      $display("Mismatch worst_case_magnitude: expected %0d actual %0d", 20'd585225, got);
    end
  endtask

  task automatic random_image;
    for (int a = 0; a < N_PIX; a++) img[a] = 8'($urandom);
    for (int k = 0; k < 9; k++) kern[k] = 8'($urandom);
    load_image;
    load_kernel;
    run_conv("random_image");
    check_results("random_image");
  endtask

  // Host traffic on the shared port while the engine runs
  task automatic host_contention;
    logic [19:0]        got;
    logic [19:0]        last_word;
    logic [`MEM_AW-1:0] a;
    int                 n;
    n         = 0;
    last_word = '0;
    run_over  = 1'b0;
    fork
      begin
        run_conv("host_contention");
        run_over = 1'b1;
      end
      begin
        while (!run_over) begin
          a = `MEM_AW'((n * 5) % N_PIX);
          host_read(a, got);
          assert (got === {12'h000, img[a]}) else begin
            errors++;
            $display("Mismatch host_contention pixel %0d: expected %0d actual %0d",
                     a, img[a], got);
          end
          last_word = 20'hC0000 | 20'(n);
          host_write(7'd127, last_word);
          n++;
        end
      end
    join
    check_results("host_contention");
    host_read(7'd127, got);
    assert (got === last_word) else begin
      errors++;
      $display("Mismatch host_contention address 127: expected %0d actual %0d",
               last_word, got);
    end
  endtask

  task automatic back_to_back;
    for (int k = 0; k < 9; k++) kern[k] = 8'(k * 29 + 3);
    load_kernel;
    done_count = 0;
    pulse_start;
    repeat (5) @(negedge clk);
    assert (busy) else begin
      errors++;
      $display("back_to_back: engine not busy before the second start");
    end
    pulse_start;  // Must be ignored
    while (!done) @(negedge clk);
    repeat (20) @(negedge clk);
    assert (done_count == 1 && !busy) else begin
      errors++;
      $display("back_to_back: %0d done pulses seen, busy %0b, one pulse expected",
               done_count, busy);
    end
    check_results("back_to_back");
  endtask

  initial begin
    seed = 32'h347428d7;
    void'($urandom(seed));
    errors      = 0;
    cycles      = 0;
    done_count  = 0;
    run_over    = 1'b0;
    reset       = 1'b1;
    start       = 1'b0;
    kernel_we   = 1'b0;
    kernel_idx  = '0;
    kernel_data = '0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_wdata  = '0;
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;

    reset_state;
    identity_kernel;
    ones_kernel_ramp;
    worst_case_magnitude;
    random_image;
    host_contention;
    back_to_back;

    $display("Summary: %0d errors after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
